// ==== sources.f ====
+incdir+common
common/isa_pkg.sv
common/dispatch_pkg.sv
hw/dispatch_ctrl.sv
hw/arch_reg_file.sv
reorder_buffer/reorder_buffer.sv
reservation_station/reservation_station.sv
hw/dispatch_stage.sv
verification/dispatch_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dispatch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sources.f \
        --top-module dispatch_stage_tb -Mdir obj_dir -o dispatch_stage_tb; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dispatch_stage_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
echo "Simulation finished cleanly"
exit 0

// ==== verification/dispatch_stage_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dispatch_defs.svh"

module dispatch_stage_tb;
    import isa_pkg::*;
    import dispatch_pkg::*;

    localparam int WAIT_LIMIT = 400;   // Cycles any wait loop may spin

    logic      clk;
    logic      reset;
    logic      dispatch_valid;
    src_ref_t  src_a;
    src_ref_t  src_b;
    logic      use_imm;
    data_t     imm;
    arch_idx_t rd_arch;
    logic      credit_return;
    logic      issue_valid;
    rob_idx_t  issue_rob_idx;
    data_t     issue_op_a;
    data_t     issue_op_b;
    logic      cdb_valid;
    rob_idx_t  cdb_rob_idx;
    data_t     cdb_data;
    logic      commit_valid;
    arch_idx_t commit_arch;
    data_t     commit_data;

    // ==============================
    // Model state
    // ==============================
    int        credits;                  // Held by the issue stage model
    int        in_flight;                // Dispatched, not yet committed
    rob_idx_t  alloc_ptr;                // Monitor copy of the ROB tail
    rob_idx_t  commit_ptr;               // Expected head
    rob_idx_t  tail_cnt;                 // Renamer's tail
    data_t     spec_val  [`ARCH_REGS];   // Value each register ends up with
    logic      ren_busy  [`ARCH_REGS];   // Pending writer in the ROB
    rob_idx_t  ren_tag   [`ARCH_REGS];
    arch_idx_t exp_arch  [`ROB_DEPTH];
    data_t     exp_data  [`ROB_DEPTH];
    data_t     exp_op_a  [`ROB_DEPTH];
    data_t     exp_op_b  [`ROB_DEPTH];
    logic      bcast     [`ROB_DEPTH];   // Result already on the CDB
    logic      dep_a     [`ROB_DEPTH];   // Producer of A still outstanding
    logic      dep_b     [`ROB_DEPTH];
    rob_idx_t  dep_a_tag [`ROB_DEPTH];
    rob_idx_t  dep_b_tag [`ROB_DEPTH];
    logic      fu_busy   [`ROB_DEPTH];   // FU holds an unsent result
    data_t     fu_sum    [`ROB_DEPTH];
    int        fu_delay  [`ROB_DEPTH];
    logic      hold_results;             // FU withholds every result
    logic      expect_stall;
    logic      drained;

    dispatch_stage i_dispatch_stage (
        .clk_i           (clk),
        .reset_i         (reset),
        .dispatch_valid_i(dispatch_valid),
        .src_a_i         (src_a),
        .src_b_i         (src_b),
        .use_imm_i       (use_imm),
        .imm_i           (imm),
        .rd_arch_i       (rd_arch),
        .credit_return_o (credit_return),
        .issue_valid_o   (issue_valid),
        .issue_rob_idx_o (issue_rob_idx),
        .issue_op_a_o    (issue_op_a),
        .issue_op_b_o    (issue_op_b),
        .cdb_valid_i     (cdb_valid),
        .cdb_rob_idx_i   (cdb_rob_idx),
        .cdb_data_i      (cdb_data),
        .commit_valid_o  (commit_valid),
        .commit_arch_o   (commit_arch),
        .commit_data_o   (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic timeout_error(input string msg);
        $display("Timeout: %s", msg);
        stop_with_failure();
    endtask

    // Source reference as the issue stage would rename it
    function automatic src_ref_t rename_src(input arch_idx_t r);
        src_ref_t src;
        if (ren_busy[r]) begin
            src = {1'b1, {(`ARCH_IDX_W-`ROB_IDX_W){1'b0}}, ren_tag[r]};
        end else begin
            src = {1'b0, r};
        end
        return src;
    endfunction

    // One issue stage cycle that sends an add when a credit is held
    task automatic issue_cycle(output logic sent);
        arch_idx_t ra;
        arch_idx_t rb;
        arch_idx_t rd;
        logic      imm_sel;
        data_t     imm_val;
        data_t     op_a;
        data_t     op_b;
        sent           = 1'b0;
        dispatch_valid = 1'b0;
        if (credits > 0) begin
            ra      = arch_idx_t'($urandom_range(7, 0));   // Small set for many hazards
            rb      = arch_idx_t'($urandom_range(7, 0));
            rd      = arch_idx_t'($urandom_range(7, 1));   // Never x0
            imm_sel = ($urandom_range(2, 0) == 0);
            imm_val = $urandom;
            op_a    = spec_val[ra];
            op_b    = imm_sel ? imm_val : spec_val[rb];
            src_a   = rename_src(ra);                     // Before rd is renamed
            src_b   = rename_src(rb);
            use_imm = imm_sel;
            imm     = imm_val;
            rd_arch = rd;
            dispatch_valid     = 1'b1;
            exp_arch[tail_cnt] = rd;
            exp_data[tail_cnt] = op_a + op_b;
            exp_op_a[tail_cnt] = op_a;
            exp_op_b[tail_cnt] = op_b;
            spec_val[rd]       = op_a + op_b;
            ren_busy[rd]       = 1'b1;
            ren_tag[rd]        = tail_cnt;
            tail_cnt           = tail_cnt + rob_idx_t'(1);
            sent               = 1'b1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_burst(input int n);
        logic sent;
        int   count;
        int   guard;
        count = 0;
        guard = 0;
        while (count < n && guard < WAIT_LIMIT) begin
            issue_cycle(sent);
            count = count + int'(sent);
            guard++;
        end
        if (count < n) timeout_error("issue stage starved of credits during a burst");
    endtask

    // ==============================
    // Monitor on pre-edge values
    // ==============================
    always @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (fu_busy[i] && fu_delay[i] > 0) fu_delay[i] = fu_delay[i] - 1;
            end
            if (issue_valid) begin                      // FU accepts every issue
                fu_busy[issue_rob_idx]  = 1'b1;
                fu_sum[issue_rob_idx]   = issue_op_a + issue_op_b;
                fu_delay[issue_rob_idx] = int'($urandom_range(5, 0));
            end
            if (cdb_valid) begin
                bcast[cdb_rob_idx] = 1'b1;
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    if (dep_a[i] && dep_a_tag[i] == cdb_rob_idx) dep_a[i] = 1'b0;
                    if (dep_b[i] && dep_b_tag[i] == cdb_rob_idx) dep_b[i] = 1'b0;
                end
            end
            if (dispatch_valid) begin                   // Same-edge CDB already counted
                dep_a[alloc_ptr]     = src_a[`ARCH_IDX_W] && !bcast[src_a[`ROB_IDX_W-1:0]];
                dep_b[alloc_ptr]     = !use_imm && src_b[`ARCH_IDX_W]
                                       && !bcast[src_b[`ROB_IDX_W-1:0]];
                dep_a_tag[alloc_ptr] = src_a[`ROB_IDX_W-1:0];
                dep_b_tag[alloc_ptr] = src_b[`ROB_IDX_W-1:0];
                bcast[alloc_ptr]     = 1'b0;
                alloc_ptr            = alloc_ptr + rob_idx_t'(1);
            end
            if (commit_valid) begin                     // Value now lives in the RF
                if (ren_busy[exp_arch[commit_ptr]] && ren_tag[exp_arch[commit_ptr]] == commit_ptr)
                    ren_busy[exp_arch[commit_ptr]] = 1'b0;
                commit_ptr = commit_ptr + rob_idx_t'(1);
            end
            in_flight = in_flight + int'(dispatch_valid) - int'(commit_valid);
            credits   = credits + int'(credit_return) - int'(dispatch_valid);
        end
    end

    // Functional unit model with one broadcast per cycle
    initial begin : fu_model
        logic hold_now;
        logic found;
        forever begin
            @(posedge clk);
            hold_now = hold_results;
            #1;
            found     = 1'b0;
            cdb_valid = 1'b0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (!found && !hold_now && fu_busy[i] && fu_delay[i] == 0) begin
                    found       = 1'b1;
                    cdb_valid   = 1'b1;
                    cdb_rob_idx = rob_idx_t'(i);
                    cdb_data    = fu_sum[i];
                    fu_busy[i]  = 1'b0;
                end
            end
        end
    end

    // ==============================
    // Checks sampled mid-cycle
    // ==============================
    a_reset_quiet : assert property (@(negedge clk)
        (reset || $fell(reset)) |-> (!issue_valid && !commit_valid && !credit_return))
        else value_error("output active during or right after reset");

    a_commit_value : assert property (@(negedge clk) disable iff (reset)
        commit_valid |-> (commit_data == exp_data[commit_ptr]))
        else value_error("commit data differs from the model sum");

    a_commit_order : assert property (@(negedge clk) disable iff (reset)
        commit_valid |-> (in_flight > 0 && commit_arch == exp_arch[commit_ptr]))
        else value_error("commit out of dispatch order");

    a_wait_producer : assert property (@(negedge clk) disable iff (reset)
        issue_valid |-> (!dep_a[issue_rob_idx] && !dep_b[issue_rob_idx]))
        else value_error("issued before the producer broadcast");

    a_issue_operands : assert property (@(negedge clk) disable iff (reset)
        issue_valid |-> (issue_op_a == exp_op_a[issue_rob_idx]
                         && issue_op_b == exp_op_b[issue_rob_idx]))
        else value_error("issued operand differs from the expected value");

    a_credit_range : assert property (@(negedge clk) disable iff (reset)
        credits >= 0 && credits <= `RS_DEPTH)
        else value_error("sender credit count out of range");

    a_rob_bound : assert property (@(negedge clk) disable iff (reset)
        credits + in_flight <= `ROB_DEPTH)
        else value_error("credits plus occupancy exceed the ROB depth");

    a_stall : assert property (@(negedge clk) disable iff (reset)
        expect_stall |-> !credit_return)
        else value_error("credit returned while the ROB is saturated");

    // Full pool and empty ROB leave nothing to return, issue or commit
    a_drained : assert property (@(negedge clk) disable iff (reset)
        drained |-> (!credit_return && !issue_valid && !commit_valid))
        else value_error("activity after the pipeline drained");

    initial begin : stimulus
        logic sent;
        int   guard;
        void'($urandom(86));
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        src_a          = '0;
        src_b          = '0;
        use_imm        = 1'b0;
        imm            = '0;
        rd_arch        = '0;
        cdb_valid      = 1'b0;
        cdb_rob_idx    = '0;
        cdb_data       = '0;
        credits        = `RS_DEPTH;
        in_flight      = 0;
        alloc_ptr      = '0;
        commit_ptr     = '0;
        tail_cnt       = '0;
        hold_results   = 1'b0;
        expect_stall   = 1'b0;
        drained        = 1'b0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            spec_val[i] = '0;
            ren_busy[i] = 1'b0;
            ren_tag[i]  = '0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            bcast[i]    = 1'b0;
            dep_a[i]    = 1'b0;
            dep_b[i]    = 1'b0;
            fu_busy[i]  = 1'b0;
            fu_delay[i] = 0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        run_burst(40);                                  // Free running

        hold_results = 1'b1;                            // Back-pressure
        repeat (60) issue_cycle(sent);
        expect_stall = 1'b1;                            // Settled by now
        repeat (10) issue_cycle(sent);
        expect_stall = 1'b0;
        hold_results = 1'b0;

        sent  = 1'b0;
        guard = 0;
        while (!sent && guard < WAIT_LIMIT) begin
            issue_cycle(sent);
            guard++;
        end
        if (!sent) timeout_error("dispatch did not resume after results were released");

        run_burst(30);

        dispatch_valid = 1'b0;
        guard          = 0;
        while ((in_flight != 0 || credits != `RS_DEPTH) && guard < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            guard++;
        end
        if (in_flight != 0 || credits != `RS_DEPTH) begin
            timeout_error("pipeline did not drain with all credits returned");
        end else begin
            drained = 1'b1;
            @(posedge clk);
            #1;
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hw/dispatch_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dispatch_defs.svh"

module dispatch_stage (
    input  logic                   clk_i,
    input  logic                   reset_i,
    // Issue stage
    input  logic                   dispatch_valid_i,
    input  isa_pkg::src_ref_t      src_a_i,
    input  isa_pkg::src_ref_t      src_b_i,
    input  logic                   use_imm_i,
    input  isa_pkg::data_t         imm_i,
    input  isa_pkg::arch_idx_t     rd_arch_i,
    output logic                   credit_return_o,
    // Functional unit
    output logic                   issue_valid_o,
    output dispatch_pkg::rob_idx_t issue_rob_idx_o,
    output isa_pkg::data_t         issue_op_a_o,
    output isa_pkg::data_t         issue_op_b_o,
    // CDB
    input  logic                   cdb_valid_i,
    input  dispatch_pkg::rob_idx_t cdb_rob_idx_i,
    input  isa_pkg::data_t         cdb_data_i,
    // Commit
    output logic                   commit_valid_o,
    output isa_pkg::arch_idx_t     commit_arch_o,
    output isa_pkg::data_t         commit_data_o
);
    import isa_pkg::*;
    import dispatch_pkg::*;

    rob_idx_t  rob_tail;
    rob_idx_t  rob_head;
    logic      alloc_en;
    logic      commit_en;
    logic      head_done;
    arch_idx_t head_arch;
    data_t     head_data;
    logic      rob_done_a;
    logic      rob_done_b;
    data_t     rob_data_a;
    data_t     rob_data_b;
    data_t     rf_data_a;
    data_t     rf_data_b;
    logic      rs_issue_en;
    logic      rs_free;

    assign commit_valid_o = commit_en;
    assign commit_arch_o  = head_arch;
    assign commit_data_o  = head_data;

    dispatch_ctrl i_dispatch_ctrl (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .dispatch_valid_i(dispatch_valid_i),
        .rs_issue_en_i   (rs_issue_en),
        .head_done_i     (head_done),
        .rob_tail_o      (rob_tail),
        .rob_head_o      (rob_head),
        .alloc_en_o      (alloc_en),
        .commit_en_o     (commit_en),
        .credit_return_o (credit_return_o)
    );

    arch_reg_file i_arch_reg_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rd_idx_a_i (src_a_i[`ARCH_IDX_W-1:0]),
        .rd_idx_b_i (src_b_i[`ARCH_IDX_W-1:0]),
        .rd_data_a_o(rf_data_a),
        .rd_data_b_o(rf_data_b),
        .wr_en_i    (commit_en),
        .wr_idx_i   (head_arch),
        .wr_data_i  (head_data)
    );

    reorder_buffer i_reorder_buffer (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .alloc_en_i   (alloc_en),
        .alloc_idx_i  (rob_tail),
        .alloc_arch_i (rd_arch_i),
        .cdb_valid_i  (cdb_valid_i),
        .cdb_rob_idx_i(cdb_rob_idx_i),
        .cdb_data_i   (cdb_data_i),
        .rd_idx_a_i   (src_a_i[`ROB_IDX_W-1:0]),  // Only meaningful with top bit set
        .rd_idx_b_i   (src_b_i[`ROB_IDX_W-1:0]),
        .rd_done_a_o  (rob_done_a),
        .rd_done_b_o  (rob_done_b),
        .rd_data_a_o  (rob_data_a),
        .rd_data_b_o  (rob_data_b),
        .head_idx_i   (rob_head),
        .head_done_o  (head_done),
        .head_arch_o  (head_arch),
        .head_data_o  (head_data)
    );

    reservation_station i_reservation_station (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .dispatch_valid_i  (dispatch_valid_i),
        .dispatch_rob_idx_i(rob_tail),
        .src_a_i           (src_a_i),
        .src_b_i           (src_b_i),
        .use_imm_i         (use_imm_i),
        .imm_i             (imm_i),
        .rf_data_a_i       (rf_data_a),
        .rf_data_b_i       (rf_data_b),
        .rob_done_a_i      (rob_done_a),
        .rob_done_b_i      (rob_done_b),
        .rob_data_a_i      (rob_data_a),
        .rob_data_b_i      (rob_data_b),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_rob_idx_i     (cdb_rob_idx_i),
        .cdb_data_i        (cdb_data_i),
        .issue_valid_o     (issue_valid_o),
        .issue_rob_idx_o   (issue_rob_idx_o),
        .issue_op_a_o      (issue_op_a_o),
        .issue_op_b_o      (issue_op_b_o),
        .issue_en_o        (rs_issue_en),
        .free_o            (rs_free)
    );

    // An owed credit stands for a freed station entry nobody has refilled
    a_credit_backed_by_entry : assert property (
        @(posedge clk_i) disable iff (reset_i)
        credit_return_o |-> rs_free
    ) else $error("credit returned with no free station entry");

endmodule

`default_nettype wire

// ==== reservation_station/reservation_station.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dispatch_defs.svh"

module reservation_station (
    input  logic                   clk_i,
    input  logic                   reset_i,
    // Dispatch side
    input  logic                   dispatch_valid_i,
    input  dispatch_pkg::rob_idx_t dispatch_rob_idx_i,
    input  isa_pkg::src_ref_t      src_a_i,
    input  isa_pkg::src_ref_t      src_b_i,
    input  logic                   use_imm_i,
    input  isa_pkg::data_t         imm_i,
    // Operand sources
    input  isa_pkg::data_t         rf_data_a_i,
    input  isa_pkg::data_t         rf_data_b_i,
    input  logic                   rob_done_a_i,
    input  logic                   rob_done_b_i,
    input  isa_pkg::data_t         rob_data_a_i,
    input  isa_pkg::data_t         rob_data_b_i,
    // Wakeup
    input  logic                   cdb_valid_i,
    input  dispatch_pkg::rob_idx_t cdb_rob_idx_i,
    input  isa_pkg::data_t         cdb_data_i,
    // Functional unit side, always accepted
    output logic                   issue_valid_o,
    output dispatch_pkg::rob_idx_t issue_rob_idx_o,
    output isa_pkg::data_t         issue_op_a_o,
    output isa_pkg::data_t         issue_op_b_o,
    output logic                   issue_en_o,
    output logic                   free_o
);
    import isa_pkg::*;
    import dispatch_pkg::*;

    logic          valid_q   [`RS_DEPTH];
    rob_idx_t      rob_idx_q [`RS_DEPTH];
    logic          rdy_a_q   [`RS_DEPTH];
    logic          rdy_b_q   [`RS_DEPTH];
    operand_slot_u slot_a_q  [`RS_DEPTH];
    operand_slot_u slot_b_q  [`RS_DEPTH];

    logic          in_rdy_a;
    logic          in_rdy_b;
    operand_slot_u in_slot_a;
    operand_slot_u in_slot_b;
    rs_idx_t       alloc_sel;   // Lowest free entry
    rs_idx_t       issue_sel;   // Lowest fully ready entry

    // Resolve one source into a slot plus ready flag
    function automatic void capture(
        input  src_ref_t      src,
        input  logic          rob_done,
        input  data_t         rob_data,
        input  data_t         rf_data,
        output logic          rdy,
        output operand_slot_u slot
    );
        rob_idx_t tag;
        tag        = src[`ROB_IDX_W-1:0];
        rdy        = 1'b1;
        slot.value = rf_data;                  // Architectural value by default
        if (src[`ARCH_IDX_W]) begin
            if (rob_done) begin
                slot.value = rob_data;         // Finished, not yet committed
            end else if (cdb_valid_i && (cdb_rob_idx_i == tag)) begin
                slot.value = cdb_data_i;       // Broadcast in the dispatch cycle
            end else begin
                rdy              = 1'b0;
                slot.wait_on.pad = '0;
                slot.wait_on.tag = tag;
            end
        end
    endfunction

    // ==============================
    // Operand select
    // ==============================
    always_comb begin
        capture(src_a_i, rob_done_a_i, rob_data_a_i, rf_data_a_i, in_rdy_a, in_slot_a);
        capture(src_b_i, rob_done_b_i, rob_data_b_i, rf_data_b_i, in_rdy_b, in_slot_b);
        if (use_imm_i) begin
            in_rdy_b        = 1'b1;
            in_slot_b.value = imm_i;           // Immediate replaces rs2
        end
    end

    // Priority scan, walks downward so the lowest index wins
    always_comb begin
        alloc_sel     = '0;
        issue_sel     = '0;
        free_o        = 1'b0;
        issue_valid_o = 1'b0;
        for (int i = `RS_DEPTH-1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_sel = rs_idx_t'(i);
                free_o    = 1'b1;
            end
            if (valid_q[i] && rdy_a_q[i] && rdy_b_q[i]) begin
                issue_sel     = rs_idx_t'(i);
                issue_valid_o = 1'b1;
            end
        end
    end

    assign issue_en_o      = issue_valid_o;  // No back-pressure from the FU
    assign issue_rob_idx_o = rob_idx_q[issue_sel];
    assign issue_op_a_o    = slot_a_q[issue_sel].value;
    assign issue_op_b_o    = slot_b_q[issue_sel].value;

    // ==============================
    // Entry state
    // ==============================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            if (issue_en_o) begin
                valid_q[issue_sel] <= 1'b0;    // Freed at the issue edge
            end
            if (dispatch_valid_i) begin
                valid_q[alloc_sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        // CDB wakeup of parked operands
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (valid_q[i] && !rdy_a_q[i] && cdb_valid_i
                    && (slot_a_q[i].wait_on.tag == cdb_rob_idx_i)) begin
                rdy_a_q[i]        <= 1'b1;
                slot_a_q[i].value <= cdb_data_i;
            end
            if (valid_q[i] && !rdy_b_q[i] && cdb_valid_i
                    && (slot_b_q[i].wait_on.tag == cdb_rob_idx_i)) begin
                rdy_b_q[i]        <= 1'b1;
                slot_b_q[i].value <= cdb_data_i;
            end
        end
        // New entry, never the same slot as a wakeup
        if (dispatch_valid_i) begin
            rob_idx_q[alloc_sel] <= dispatch_rob_idx_i;
            rdy_a_q[alloc_sel]   <= in_rdy_a;
            rdy_b_q[alloc_sel]   <= in_rdy_b;
            slot_a_q[alloc_sel]  <= in_slot_a;
            slot_b_q[alloc_sel]  <= in_slot_b;
        end
    end

    a_no_dispatch_when_full : assert property (
        @(posedge clk_i) disable iff (reset_i)
        dispatch_valid_i |-> free_o
    ) else $error("dispatch into a full reservation station");

endmodule

`default_nettype wire

// ==== reorder_buffer/reorder_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dispatch_defs.svh"

module reorder_buffer (
    input  logic                   clk_i,
    input  logic                   reset_i,
    // Allocation at the tail
    input  logic                   alloc_en_i,
    input  dispatch_pkg::rob_idx_t alloc_idx_i,
    input  isa_pkg::arch_idx_t     alloc_arch_i,
    // Result broadcast
    input  logic                   cdb_valid_i,
    input  dispatch_pkg::rob_idx_t cdb_rob_idx_i,
    input  isa_pkg::data_t         cdb_data_i,
    // Operand lookups from the dispatching instruction
    input  dispatch_pkg::rob_idx_t rd_idx_a_i,
    input  dispatch_pkg::rob_idx_t rd_idx_b_i,
    output logic                   rd_done_a_o,
    output logic                   rd_done_b_o,
    output isa_pkg::data_t         rd_data_a_o,
    output isa_pkg::data_t         rd_data_b_o,
    // Head view for commit
    input  dispatch_pkg::rob_idx_t head_idx_i,
    output logic                   head_done_o,
    output isa_pkg::arch_idx_t     head_arch_o,
    output isa_pkg::data_t         head_data_o
);
    import isa_pkg::*;
    import dispatch_pkg::*;

    logic      done_q   [`ROB_DEPTH];  // Result written back
    arch_idx_t arch_q   [`ROB_DEPTH];  // Destination register
    data_t     result_q [`ROB_DEPTH];

    // ==============================
    // Done flags
    // ==============================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                done_q[i] <= 1'b0;
            end
        end else begin
            // Cleared only on reallocation, so a just-committed entry still reads done
            if (alloc_en_i) begin
                done_q[alloc_idx_i] <= 1'b0;
            end
            if (cdb_valid_i) begin
                done_q[cdb_rob_idx_i] <= 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (alloc_en_i) begin
            arch_q[alloc_idx_i] <= alloc_arch_i;
        end
        if (cdb_valid_i) begin
            result_q[cdb_rob_idx_i] <= cdb_data_i;
        end
    end

    assign rd_done_a_o = done_q[rd_idx_a_i];
    assign rd_done_b_o = done_q[rd_idx_b_i];
    assign rd_data_a_o = result_q[rd_idx_a_i];
    assign rd_data_b_o = result_q[rd_idx_b_i];

    assign head_done_o = done_q[head_idx_i];   // Qualified by occupancy in the controller
    assign head_arch_o = arch_q[head_idx_i];
    assign head_data_o = result_q[head_idx_i];

    // FU only broadcasts what it was issued, and each index once per allocation
    a_cdb_single_write : assert property (
        @(posedge clk_i) disable iff (reset_i)
        cdb_valid_i |-> !done_q[cdb_rob_idx_i]
    ) else $error("CDB write to an entry already done");

endmodule

`default_nettype wire

// ==== hw/arch_reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dispatch_defs.svh"

module arch_reg_file (
    input  logic               clk_i,
    input  logic               reset_i,
    input  isa_pkg::arch_idx_t rd_idx_a_i,
    input  isa_pkg::arch_idx_t rd_idx_b_i,
    output isa_pkg::data_t     rd_data_a_o,
    output isa_pkg::data_t     rd_data_b_o,
    input  logic               wr_en_i,   // Commit strobe
    input  isa_pkg::arch_idx_t wr_idx_i,
    input  isa_pkg::data_t     wr_data_i
);
    import isa_pkg::*;

    data_t regs_q [`ARCH_REGS];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            regs_q[wr_idx_i] <= wr_data_i;  // x0 stays zero
        end
    end

    // Combinational reads, no write bypass
    assign rd_data_a_o = regs_q[rd_idx_a_i];
    assign rd_data_b_o = regs_q[rd_idx_b_i];

endmodule

`default_nettype wire

// ==== hw/dispatch_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "dispatch_defs.svh"

module dispatch_ctrl (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   dispatch_valid_i,
    input  logic                   rs_issue_en_i,
    input  logic                   head_done_i,
    output dispatch_pkg::rob_idx_t rob_tail_o,
    output dispatch_pkg::rob_idx_t rob_head_o,
    output logic                   alloc_en_o,
    output logic                   commit_en_o,
    output logic                   credit_return_o
);
    import dispatch_pkg::*;

    rob_idx_t              tail_q;            // Next entry to allocate
    rob_idx_t              head_q;            // Oldest in-flight entry
    logic [`ROB_IDX_W:0]   rob_count_q;       // Occupancy 0..ROB_DEPTH
    credit_cnt_t           sender_credits_q;  // Credits held by issue stage
    credit_cnt_t           owed_q;            // Freed station entries not yet returned
    logic [`ROB_IDX_W+1:0] pledged;

    // Every dispatch takes the tail slot
    assign alloc_en_o  = dispatch_valid_i;

    // Empty ROB may still show a stale done flag at head
    assign commit_en_o = head_done_i && (rob_count_q != '0);

    // Worst case ROB demand: live entries plus what the sender may still send
    assign pledged = {2'b00, sender_credits_q} + {1'b0, rob_count_q};

    // One credit per cycle, held back while the ROB could overflow
    assign credit_return_o = (owed_q != '0) && (pledged < `ROB_DEPTH);

    assign rob_tail_o = tail_q;
    assign rob_head_o = head_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tail_q           <= '0;
            head_q           <= '0;
            rob_count_q      <= '0;
            sender_credits_q <= `RS_DEPTH;  // Sender starts with a full pool
            owed_q           <= '0;
        end else begin
            if (alloc_en_o) begin
                tail_q <= tail_q + rob_idx_t'(1);  // Wraps mod 8
            end
            if (commit_en_o) begin
                head_q <= head_q + rob_idx_t'(1);
            end
            rob_count_q <= rob_count_q + {{`ROB_IDX_W{1'b0}}, alloc_en_o}
                                       - {{`ROB_IDX_W{1'b0}}, commit_en_o};
            sender_credits_q <= sender_credits_q + {2'b00, credit_return_o}
                                                 - {2'b00, dispatch_valid_i};
            owed_q <= owed_q + {2'b00, rs_issue_en_i} - {2'b00, credit_return_o};
        end
    end

    // ==============================
    // Flow control checks
    // ==============================
    a_dispatch_needs_credit : assert property (
        @(posedge clk_i) disable iff (reset_i)
        dispatch_valid_i |-> (sender_credits_q != '0)
    ) else $error("dispatch with no credit held");

    a_rob_no_overflow : assert property (
        @(posedge clk_i) disable iff (reset_i)
        alloc_en_o |-> (rob_count_q < `ROB_DEPTH)
    ) else $error("allocation into a full reorder buffer");

endmodule

`default_nettype wire

// ==== common/dispatch_pkg.sv ====
`default_nettype none

`include "dispatch_defs.svh"

package dispatch_pkg;

    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;                 // ROB entry
    typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;           // Station entry
    typedef logic [$clog2(`RS_DEPTH+1)-1:0] credit_cnt_t;     // 0..RS_DEPTH

    // ==============================
    // Operand slot of a station entry
    // ==============================
    // Ready flag set: slot carries the operand value
    // Ready flag clear: slot carries the producer's ROB index
    typedef union packed {
        isa_pkg::data_t value;
        struct packed {
            logic [`DATA_W-`ROB_IDX_W-1:0] pad;  // Zero while waiting
            rob_idx_t                      tag;  // Producer to wait for
        } wait_on;
    } operand_slot_u;

endpackage

`default_nettype wire

// ==== common/isa_pkg.sv ====
`default_nettype none

`include "dispatch_defs.svh"

package isa_pkg;

    // One architectural data word
    typedef logic [`DATA_W-1:0] data_t;

    // Register index, x0 hardwired to zero
    typedef logic [`ARCH_IDX_W-1:0] arch_idx_t;

    // Renamed source reference
    // Top bit set means low bits hold a ROB index
    // Top bit clear means low bits hold an architectural index
    typedef logic [`ARCH_IDX_W:0] src_ref_t;

endpackage

`default_nettype wire

// ==== common/dispatch_defs.svh ====
`ifndef DISPATCH_DEFS_SVH
`define DISPATCH_DEFS_SVH

// ==============================
// Datapath sizing
// ==============================
`define DATA_W      32  // RV32I word
`define ARCH_REGS   32  // x0..x31
`define ARCH_IDX_W  5

// ==============================
// Buffer depths
// ==============================
`define ROB_DEPTH   8   // Power of two, pointers wrap naturally
`define ROB_IDX_W   3
`define RS_DEPTH    4   // Also the issue stage credit pool

`endif
